/* hdl/phold_pkg.sv */
package phold_pkg;

   // widths
   localparam int MSG_WID        = 32;
   localparam int TIME_WID       = 16;
   localparam int NB_LPID        = 3;
   localparam int NB_RND         = 24;
   localparam int HIST_WID       = 32;
   localparam int NB_HIST_DEPTH  = 4;
   localparam int NB_HIST_ADDR   = 8;
   localparam int RBK_OFFSET_WID = 8;
   localparam int DLY_CNT_WID    = 8;

   // message layout: time, target, type, zero fill
   localparam int EVT_TYPE_POS = TIME_WID + NB_LPID;
   localparam int MSG_PAD      = MSG_WID - 1 - NB_LPID - TIME_WID;

   // history entry layout: time, type, offset, target, zero fill
   localparam int ENT_TYPE_POS = TIME_WID;
   localparam int ENT_OFF_POS  = TIME_WID + 1;
   localparam int ENT_TGT_POS  = TIME_WID + 1 + RBK_OFFSET_WID;
   localparam int ENT_PAD      = HIST_WID - NB_LPID - RBK_OFFSET_WID - 1 - TIME_WID;

   // event type codes
   localparam logic CANCEL_EVT  = 1'b1;
   localparam logic REGULAR_EVT = 1'b0;

   // random word slices
   localparam int RND_INC_POS = 0;
   localparam int RND_INC_WID = 6;
   localparam int RND_TGT_POS = 8;
   localparam int RND_DLY_POS = 16;
   localparam int RND_DLY_WID = 4;

   localparam logic [TIME_WID-1:0]    MIN_EVT_GAP = 16'd10;
   localparam logic [DLY_CNT_WID-1:0] FIXED_DELAY = 8'd10;
   localparam logic [4:0]             BUF_DEPTH   = 5'd16;

   // event phases driven by the sequencer
   localparam int         PHASE_WID = 3;
   localparam logic [2:0] PH_IDLE   = 3'd0;
   localparam logic [2:0] PH_STALL  = 3'd1;
   localparam logic [2:0] PH_READ   = 3'd2;
   localparam logic [2:0] PH_DELAY  = 3'd3;
   localparam logic [2:0] PH_GEN    = 3'd4;
   localparam logic [2:0] PH_WRITE  = 3'd5;
   localparam logic [2:0] PH_SEND   = 3'd6;
   localparam logic [2:0] PH_WAIT   = 3'd7;

   // history access states
   localparam logic [1:0] ACC_IDLE  = 2'd0;
   localparam logic [1:0] ACC_SETUP = 2'd1;
   localparam logic [1:0] ACC_REQ   = 2'd2;

endpackage

/* hdl/phold_fifo.sv */
module phold_fifo
   import phold_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     clear,
   input  logic                     wr_en,
   input  logic [HIST_WID-1:0]      din,
   input  logic                     rd_en,
   output logic [HIST_WID-1:0]      dout,
   output logic                     empty,
   output logic [NB_HIST_DEPTH:0]   count
);

   logic [HIST_WID-1:0]      mem [BUF_DEPTH];
   logic [NB_HIST_DEPTH-1:0] wr_ptr;
   logic [NB_HIST_DEPTH-1:0] rd_ptr;
   logic                     do_wr;
   logic                     do_rd;

   // writes to a full buffer are dropped
   assign do_wr = wr_en && (count != BUF_DEPTH);
   assign do_rd = rd_en && !empty;

   // head is always visible
   assign dout  = mem[rd_ptr];
   assign empty = (count == '0);

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

endmodule

/* hdl/core_sequencer.sv */
module core_sequencer
   import phold_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 evt_accept,
   input  logic                 stall,
   input  logic                 hist_done,
   input  logic                 delay_done,
   input  logic                 send_done,
   output logic [PHASE_WID-1:0] phase,
   output logic                 evt_clear,
   output logic                 hist_go,
   output logic                 send_start,
   output logic                 ready
);

   logic [PHASE_WID-1:0] phase_nxt;

   always_comb begin
      phase_nxt = phase;
      case (phase)
         PH_IDLE:  if (evt_accept) phase_nxt = PH_STALL;
         PH_STALL: if (!stall) phase_nxt = PH_READ;
         PH_READ:  if (hist_done) phase_nxt = PH_DELAY;
         PH_DELAY: if (delay_done) phase_nxt = PH_GEN;
         PH_GEN:   phase_nxt = PH_WRITE;
         PH_WRITE: if (hist_done) phase_nxt = PH_SEND;
         PH_SEND:  phase_nxt = PH_WAIT;
         PH_WAIT:  if (send_done) phase_nxt = PH_IDLE;
         default:  phase_nxt = PH_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase      <= PH_IDLE;
         ready      <= 1'b0;
         evt_clear  <= 1'b0;
         hist_go    <= 1'b0;
         send_start <= 1'b0;
      end else begin
         phase      <= phase_nxt;
         ready      <= (phase_nxt == PH_IDLE);
         evt_clear  <= evt_accept;
         // one pulse in the first cycle of each history phase
         hist_go    <= (phase_nxt == PH_READ && phase != PH_READ) ||
                       (phase_nxt == PH_WRITE && phase != PH_WRITE);
         send_start <= (phase_nxt == PH_SEND);
      end
   end

endmodule

/* hdl/event_generator.sv */
module event_generator
   import phold_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 evt_accept,
   input  logic [NB_RND-1:0]    rnd_in,
   input  logic [TIME_WID-1:0]  cur_time,
   input  logic [NB_LPID-1:0]   lp_mask,
   input  logic [PHASE_WID-1:0] phase,
   output logic                 delay_done,
   output logic [TIME_WID-1:0]  new_time,
   output logic [NB_LPID-1:0]   new_target
);

   logic [NB_RND-1:0]      rnd_q;
   logic [DLY_CNT_WID-1:0] dly_cnt;
   logic [DLY_CNT_WID-1:0] dly_len;

   always_ff @(posedge clk) begin
      if (evt_accept)
         rnd_q <= rnd_in;
   end

   // base delay stretched by the random nibble
   assign dly_len = FIXED_DELAY + DLY_CNT_WID'(rnd_q[RND_DLY_POS +: RND_DLY_WID]);

   always_ff @(posedge clk) begin
      if (!rst_n)
         dly_cnt <= '0;
      else if (phase == PH_DELAY)
         dly_cnt <= dly_cnt + 1'b1;
      else
         dly_cnt <= '0;
   end

   assign delay_done = (phase == PH_DELAY) && (dly_cnt >= dly_len);

   // settles well before the generate phase
   always_ff @(posedge clk) begin
      new_time   <= cur_time + MIN_EVT_GAP + TIME_WID'(rnd_q[RND_INC_POS +: RND_INC_WID]);
      new_target <= rnd_q[RND_TGT_POS +: NB_LPID] & lp_mask;
   end

endmodule

/* hdl/history_filter.sv */
module history_filter
   import phold_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [PHASE_WID-1:0]     phase,
   input  logic                     hist_go,
   input  logic                     evt_clear,
   input  logic [NB_LPID-1:0]       cur_lp,
   input  logic [TIME_WID-1:0]      cur_time,
   input  logic                     cur_type,
   input  logic [TIME_WID-1:0]      gvt,
   input  logic [NB_HIST_DEPTH-1:0] hist_size,
   input  logic [TIME_WID-1:0]      new_time,
   input  logic [NB_LPID-1:0]       new_target,
   input  logic                     hist_access_grant,
   input  logic [HIST_WID-1:0]      hist_data_rd,
   output logic                     hist_done,
   output logic                     hist_rq,
   output logic                     hist_wr_en,
   output logic [NB_HIST_ADDR-1:0]  hist_addr,
   output logic [HIST_WID-1:0]      hist_data_wr,
   output logic                     rollback_push,
   output logic [HIST_WID-1:0]      rollback_entry,
   output logic                     discard_cur,
   output logic                     gen_cancel,
   output logic [MSG_WID-1:0]       cancel_msg
);

   logic [1:0]                acc_state;
   logic [NB_HIST_DEPTH:0]    acc_idx;
   logic [NB_HIST_DEPTH:0]    acc_len;
   logic                      is_write;
   logic [HIST_WID-1:0]       rd_q;
   logic                      rd_vld;
   logic [TIME_WID-1:0]       ent_time;
   logic                      ent_type;
   logic [RBK_OFFSET_WID-1:0] ent_off;
   logic [NB_LPID-1:0]        ent_tgt;
   logic                      expired;
   logic                      annihilate;
   logic                      rollback;
   logic                      append;
   logic [TIME_WID-1:0]       gap;
   logic                      wb_wr;
   logic                      wb_rd;
   logic                      wb_empty;
   logic [HIST_WID-1:0]       wb_din;
   logic [HIST_WID-1:0]       wb_dout;
   logic [NB_HIST_DEPTH:0]    wb_count;

   assign is_write = (phase == PH_WRITE);

   // access engine, one entry per request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_state  <= ACC_IDLE;
         acc_idx    <= '0;
         acc_len    <= '0;
         hist_rq    <= 1'b0;
         hist_wr_en <= 1'b0;
         hist_done  <= 1'b0;
         rd_vld     <= 1'b0;
      end else begin
         hist_done <= 1'b0;
         rd_vld    <= 1'b0;
         case (acc_state)
            ACC_IDLE: begin
               acc_idx <= '0;
               acc_len <= is_write ? wb_count : {1'b0, hist_size};
               if (hist_go) begin
                  if (is_write ? wb_empty : (hist_size == '0))
                     hist_done <= 1'b1;
                  else
                     acc_state <= ACC_SETUP;
               end
            end
            ACC_SETUP: begin
               hist_rq    <= 1'b1;
               hist_wr_en <= is_write;
               acc_state  <= ACC_REQ;
            end
            ACC_REQ: begin
               if (hist_access_grant) begin
                  hist_rq    <= 1'b0;
                  hist_wr_en <= 1'b0;
                  rd_vld     <= !hist_wr_en;
                  acc_idx    <= acc_idx + 1'b1;
                  if (acc_idx == acc_len - 1'b1) begin
                     hist_done <= 1'b1;
                     acc_state <= ACC_IDLE;
                  end else begin
                     acc_state <= ACC_SETUP;
                  end
               end
            end
            default: acc_state <= ACC_IDLE;
         endcase
      end
   end

   // address and data held from setup until grant
   always_ff @(posedge clk) begin
      if (acc_state == ACC_SETUP) begin
         hist_addr    <= NB_HIST_ADDR'({cur_lp, acc_idx[NB_HIST_DEPTH-1:0]});
         hist_data_wr <= wb_dout;
      end
      if (hist_rq && !hist_wr_en && hist_access_grant)
         rd_q <= hist_data_rd;
   end

   assign ent_time = rd_q[TIME_WID-1:0];
   assign ent_type = rd_q[ENT_TYPE_POS];
   assign ent_off  = rd_q[ENT_OFF_POS +: RBK_OFFSET_WID];
   assign ent_tgt  = rd_q[ENT_TGT_POS +: NB_LPID];

   // classification, first matching rule wins
   assign expired    = ent_time < gvt;
   assign annihilate = rd_vld && !expired && !discard_cur &&
                       (ent_type != cur_type) && (ent_time == cur_time);
   assign rollback   = rd_vld && !expired && !annihilate &&
                       (cur_type == REGULAR_EVT) && (ent_type == REGULAR_EVT) &&
                       (ent_time > cur_time);

   assign rollback_push  = rollback;
   assign rollback_entry = rd_q;

   always_ff @(posedge clk) begin
      if (!rst_n || evt_clear) begin
         discard_cur <= 1'b0;
         gen_cancel  <= 1'b0;
      end else if (annihilate) begin
         discard_cur <= 1'b1;
         gen_cancel  <= (cur_type == CANCEL_EVT);
      end
   end

   // anti-message already spawned a child, so cancel the child
   always_ff @(posedge clk) begin
      if (annihilate && cur_type == CANCEL_EVT)
         cancel_msg <= {{MSG_PAD{1'b0}}, CANCEL_EVT, ent_tgt,
                        ent_time + TIME_WID'(ent_off)};
   end

   assign gap    = new_time - cur_time;
   assign append = (phase == PH_GEN) && !discard_cur;
   assign wb_wr  = append || (rd_vld && !expired && !annihilate && !rollback);
   assign wb_din = append ?
                   {{ENT_PAD{1'b0}}, new_target, gap[RBK_OFFSET_WID-1:0], cur_type, cur_time} :
                   rd_q;
   assign wb_rd  = hist_rq && hist_wr_en && hist_access_grant;

   phold_fifo wb_buf (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (evt_clear),
      .wr_en (wb_wr),
      .din   (wb_din),
      .rd_en (wb_rd),
      .dout  (wb_dout),
      .empty (wb_empty),
      .count (wb_count)
   );

endmodule

/* hdl/event_sender.sv */
module event_sender
   import phold_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                evt_clear,
   input  logic                send_start,
   input  logic                ack,
   input  logic                rollback_push,
   input  logic [HIST_WID-1:0] rollback_entry,
   input  logic                discard_cur,
   input  logic                gen_cancel,
   input  logic [MSG_WID-1:0]  cancel_msg,
   input  logic [NB_LPID-1:0]  cur_lp,
   input  logic                cur_type,
   input  logic [TIME_WID-1:0] new_time,
   input  logic [NB_LPID-1:0]  new_target,
   output logic                new_event_ready,
   output logic [MSG_WID-1:0]  out_event_msg,
   output logic                send_done
);

   logic [HIST_WID-1:0]       rb_dout;
   logic                      rb_empty;
   logic                      rb_pop;
   logic                      reissue;
   logic [TIME_WID-1:0]       rb_time;
   logic [RBK_OFFSET_WID-1:0] rb_off;
   logic [NB_LPID-1:0]        rb_tgt;
   logic [MSG_WID-1:0]        first_msg;
   logic [MSG_WID-1:0]        rbk_cncl_msg;
   logic [MSG_WID-1:0]        rbk_evt_msg;

   assign rb_time = rb_dout[TIME_WID-1:0];
   assign rb_off  = rb_dout[ENT_OFF_POS +: RBK_OFFSET_WID];
   assign rb_tgt  = rb_dout[ENT_TGT_POS +: NB_LPID];

   assign rbk_cncl_msg = {{MSG_PAD{1'b0}}, CANCEL_EVT, rb_tgt, rb_time + TIME_WID'(rb_off)};
   assign rbk_evt_msg  = {{MSG_PAD{1'b0}}, REGULAR_EVT, cur_lp, rb_time};

   // cancel, null or the freshly generated event
   always_comb begin
      if (discard_cur && gen_cancel)
         first_msg = cancel_msg;
      else if (discard_cur || cur_type == CANCEL_EVT)
         first_msg = {{MSG_PAD{1'b0}}, CANCEL_EVT, {(NB_LPID + TIME_WID){1'b0}}};
      else
         first_msg = {{MSG_PAD{1'b0}}, REGULAR_EVT, new_target, new_time};
   end

   // entry leaves the buffer with its re-issued event
   assign rb_pop = new_event_ready && ack && reissue;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         new_event_ready <= 1'b0;
         send_done       <= 1'b0;
         reissue         <= 1'b0;
      end else begin
         send_done <= 1'b0;
         if (send_start) begin
            new_event_ready <= 1'b1;
            reissue         <= 1'b0;
         end else if (new_event_ready && ack) begin
            if (reissue) begin
               reissue <= 1'b0;
            end else if (!rb_empty) begin
               reissue <= 1'b1;
            end else begin
               new_event_ready <= 1'b0;
               send_done       <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (send_start)
         out_event_msg <= first_msg;
      else if (new_event_ready && ack)
         out_event_msg <= reissue ? rbk_evt_msg : rbk_cncl_msg;
   end

   phold_fifo rb_buf (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (evt_clear),
      .wr_en (rollback_push),
      .din   (rollback_entry),
      .rd_en (rb_pop),
      .dout  (rb_dout),
      .empty (rb_empty),
      .count ()
   );

endmodule

/* hdl/phold_core.sv */
module phold_core
   import phold_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     event_valid,
   input  logic [MSG_WID-1:0]       cur_event_msg,
   input  logic [TIME_WID-1:0]      global_time,
   input  logic [NB_RND-1:0]        random_in,
   input  logic [NB_LPID-1:0]       lp_mask,
   input  logic                     stall,
   input  logic                     ack,
   input  logic [HIST_WID-1:0]      hist_data_rd,
   input  logic                     hist_access_grant,
   input  logic [NB_HIST_DEPTH-1:0] hist_size,
   output logic                     ready,
   output logic                     new_event_ready,
   output logic [MSG_WID-1:0]       out_event_msg,
   output logic                     hist_rq,
   output logic                     hist_wr_en,
   output logic [NB_HIST_ADDR-1:0]  hist_addr,
   output logic [HIST_WID-1:0]      hist_data_wr
);

   logic                 evt_accept;
   logic [NB_LPID-1:0]   cur_lp;
   logic [TIME_WID-1:0]  cur_time;
   logic                 cur_type;
   logic [TIME_WID-1:0]  gvt;
   logic [PHASE_WID-1:0] phase;
   logic                 evt_clear;
   logic                 hist_go;
   logic                 hist_done;
   logic                 delay_done;
   logic                 send_start;
   logic                 send_done;
   logic [TIME_WID-1:0]  new_time;
   logic [NB_LPID-1:0]   new_target;
   logic                 rollback_push;
   logic [HIST_WID-1:0]  rollback_entry;
   logic                 discard_cur;
   logic                 gen_cancel;
   logic [MSG_WID-1:0]   cancel_msg;

   assign evt_accept = event_valid && ready;

   // fields of the event in flight
   always_ff @(posedge clk) begin
      if (evt_accept) begin
         cur_time <= cur_event_msg[TIME_WID-1:0];
         cur_lp   <= cur_event_msg[TIME_WID +: NB_LPID];
         cur_type <= cur_event_msg[EVT_TYPE_POS];
         gvt      <= global_time;
      end
   end

   core_sequencer u_seq (
      .clk        (clk),
      .rst_n      (rst_n),
      .evt_accept (evt_accept),
      .stall      (stall),
      .hist_done  (hist_done),
      .delay_done (delay_done),
      .send_done  (send_done),
      .phase      (phase),
      .evt_clear  (evt_clear),
      .hist_go    (hist_go),
      .send_start (send_start),
      .ready      (ready)
   );

   event_generator u_gen (
      .clk        (clk),
      .rst_n      (rst_n),
      .evt_accept (evt_accept),
      .rnd_in     (random_in),
      .cur_time   (cur_time),
      .lp_mask    (lp_mask),
      .phase      (phase),
      .delay_done (delay_done),
      .new_time   (new_time),
      .new_target (new_target)
   );

   history_filter u_filt (
      .clk               (clk),
      .rst_n             (rst_n),
      .phase             (phase),
      .hist_go           (hist_go),
      .evt_clear         (evt_clear),
      .cur_lp            (cur_lp),
      .cur_time          (cur_time),
      .cur_type          (cur_type),
      .gvt               (gvt),
      .hist_size         (hist_size),
      .new_time          (new_time),
      .new_target        (new_target),
      .hist_access_grant (hist_access_grant),
      .hist_data_rd      (hist_data_rd),
      .hist_done         (hist_done),
      .hist_rq           (hist_rq),
      .hist_wr_en        (hist_wr_en),
      .hist_addr         (hist_addr),
      .hist_data_wr      (hist_data_wr),
      .rollback_push     (rollback_push),
      .rollback_entry    (rollback_entry),
      .discard_cur       (discard_cur),
      .gen_cancel        (gen_cancel),
      .cancel_msg        (cancel_msg)
   );

   event_sender u_send (
      .clk             (clk),
      .rst_n           (rst_n),
      .evt_clear       (evt_clear),
      .send_start      (send_start),
      .ack             (ack),
      .rollback_push   (rollback_push),
      .rollback_entry  (rollback_entry),
      .discard_cur     (discard_cur),
      .gen_cancel      (gen_cancel),
      .cancel_msg      (cancel_msg),
      .cur_lp          (cur_lp),
      .cur_type        (cur_type),
      .new_time        (new_time),
      .new_target      (new_target),
      .new_event_ready (new_event_ready),
      .out_event_msg   (out_event_msg),
      .send_done       (send_done)
   );

endmodule

/* verification/phold_core_asserts.sv */
module phold_core_asserts
   import phold_pkg::*;
(
   input logic                    clk,
   input logic                    rst_n,
   input logic                    event_valid,
   input logic                    ready,
   input logic                    stall,
   input logic                    ack,
   input logic                    new_event_ready,
   input logic [MSG_WID-1:0]      out_event_msg,
   input logic                    hist_rq,
   input logic                    hist_wr_en,
   input logic                    hist_access_grant,
   input logic [NB_HIST_ADDR-1:0] hist_addr,
   input logic [HIST_WID-1:0]     hist_data_wr,
   input logic [PHASE_WID-1:0]    phase
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;

   // output word held until the consumer takes it
   msg_hold: assert property (@(posedge clk) disable iff (!rst_n)
      new_event_ready && !ack |=> new_event_ready && $stable(out_event_msg))
      else begin
         $error("out_event_msg or new_event_ready changed before ack");
         fail_cnt++;
      end

   // request fields frozen until grant
   req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      hist_rq && !hist_access_grant |=> hist_rq && $stable(hist_addr) &&
                                        $stable(hist_data_wr) && $stable(hist_wr_en))
      else begin
         $error("history request dropped or changed before grant");
         fail_cnt++;
      end

   idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> !hist_rq && !new_event_ready)
      else begin
         $error("history request or output message while ready");
         fail_cnt++;
      end

   stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      phase == PH_STALL |-> !hist_rq)
      else begin
         $error("history request during stall-wait");
         fail_cnt++;
      end

   stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      stall && phase == PH_STALL |=> phase == PH_STALL)
      else begin
         $error("core left stall-wait while stall was high");
         fail_cnt++;
      end

   busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
      event_valid && ready |=> !ready)
      else begin
         $error("ready still high after an accepted event");
         fail_cnt++;
      end

   // ready comes back two cycles after the last ack
   ready_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ready) && $past(rst_n, 2) |-> $past(new_event_ready && ack, 2))
      else begin
         $error("ready returned without a final ack");
         fail_cnt++;
      end

endmodule

bind phold_core phold_core_asserts u_asserts (
   .clk               (clk),
   .rst_n             (rst_n),
   .event_valid       (event_valid),
   .ready             (ready),
   .stall             (stall),
   .ack               (ack),
   .new_event_ready   (new_event_ready),
   .out_event_msg     (out_event_msg),
   .hist_rq           (hist_rq),
   .hist_wr_en        (hist_wr_en),
   .hist_access_grant (hist_access_grant),
   .hist_addr         (hist_addr),
   .hist_data_wr      (hist_data_wr),
   .phase             (phase)
);

/* verification/phold_core_tb.sv */
module phold_core_tb
   import phold_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     event_valid;
   logic [MSG_WID-1:0]       cur_event_msg;
   logic [TIME_WID-1:0]      global_time;
   logic [NB_RND-1:0]        random_in;
   logic [NB_LPID-1:0]       lp_mask;
   logic                     stall;
   logic                     ack;
   logic [HIST_WID-1:0]      hist_data_rd = '0;
   logic                     hist_access_grant = 1'b0;
   logic [NB_HIST_DEPTH-1:0] hist_size;
   logic                     ready;
   logic                     new_event_ready;
   logic [MSG_WID-1:0]       out_event_msg;
   logic                     hist_rq;
   logic                     hist_wr_en;
   logic [NB_HIST_ADDR-1:0]  hist_addr;
   logic [HIST_WID-1:0]      hist_data_wr;

   logic [HIST_WID-1:0]      mem [256];
   logic [31:0]              rng_state = 32'h8683_6025;
   int                       grant_wait = 0;
   logic [NB_HIST_ADDR-1:0]  wr_addrs [$];
   logic [HIST_WID-1:0]      wr_datas [$];
   logic [MSG_WID-1:0]       got [$];
   logic [MSG_WID-1:0]       exp_msgs [$];
   logic [HIST_WID-1:0]      exp_wr [$];
   logic [NB_RND-1:0]        rnd;
   logic [TIME_WID-1:0]      new_t;
   logic [NB_LPID-1:0]       new_tgt;
   int                       n_tests = 0;
   int                       n_checks = 0;
   int                       n_errors = 0;
   int                       test_errors = 0;
   logic                     hung = 1'b0;
   logic                     all_done = 1'b0;

   always #50 clk = ~clk;

   phold_core DUT (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // type bit above target above time
   function automatic logic [MSG_WID-1:0] make_msg(input logic typ,
                                                   input logic [NB_LPID-1:0] tgt,
                                                   input logic [TIME_WID-1:0] t);
      return {12'd0, typ, tgt, t};
   endfunction

   // target, offset, type, time from the top down
   function automatic logic [HIST_WID-1:0] make_entry(input logic [NB_LPID-1:0] tgt,
                                                      input logic [7:0] off,
                                                      input logic typ,
                                                      input logic [TIME_WID-1:0] t);
      return {4'd0, tgt, off, typ, t};
   endfunction

   // history memory, grants one or two cycles after a request shows up
   always @(negedge clk) begin
      if (!rst_n || hist_access_grant) begin
         hist_access_grant = 1'b0;
         grant_wait = 0;
      end else if (hist_rq && grant_wait == 0) begin
         rng_state = xorshift(rng_state);
         grant_wait = 1 + int'(rng_state[0]);
      end else if (hist_rq) begin
         grant_wait = grant_wait - 1;
         if (grant_wait == 0) begin
            hist_access_grant = 1'b1;
            hist_data_rd = mem[hist_addr];
            if (hist_wr_en) begin
               mem[hist_addr] = hist_data_wr;
               wr_addrs.push_back(hist_addr);
               wr_datas.push_back(hist_data_wr);
            end
         end
      end
   end

   task automatic check_value(input logic [31:0] got_v, input logic [31:0] exp_v,
                              input string what);
      n_checks++;
      assert (got_v === exp_v)
      else begin
         $display("ERR %0d ns: %s is %h, expected %h", $time, what, got_v, exp_v);
         test_errors++;
      end
   endtask

   task automatic wait_level(input bit on_output, input string what);
      int n;
      n = 0;
      while (!(on_output ? new_event_ready : ready) && n < 200) begin
         @(negedge clk);
         n++;
      end
      if (!(on_output ? new_event_ready : ready)) begin
         $display("timeout: the core never raised %s", what);
         n_errors++;
         hung = 1'b1;
         // parked here, the closing process ends the run
         wait (!hung);
      end
   endtask

   task automatic start_test();
      got.delete();
      exp_msgs.delete();
      exp_wr.delete();
      wr_addrs.delete();
      wr_datas.delete();
      test_errors = 0;
      for (int a = 0; a < 256; a++)
         mem[a] = {4{8'(a)}} ^ 32'hc35a_a53c;
   endtask

   // one event in, every output message acked after a one-cycle hold
   task automatic run_event(input logic [NB_LPID-1:0] lp, input logic typ,
                            input logic [TIME_WID-1:0] t, input logic [TIME_WID-1:0] gvt,
                            input int size, input int stall_cycles);
      int n;
      wait_level(1'b0, "ready");
      rng_state = xorshift(rng_state);
      rnd = rng_state[NB_RND-1:0];
      event_valid = 1'b1;
      cur_event_msg = make_msg(typ, lp, t);
      global_time = gvt;
      random_in = rnd;
      hist_size = NB_HIST_DEPTH'(size);
      stall = (stall_cycles > 0);
      @(negedge clk);
      event_valid = 1'b0;
      repeat (stall_cycles) @(negedge clk);
      stall = 1'b0;
      wait_level(1'b1, "new_event_ready");
      n = 0;
      while (new_event_ready && n < 16) begin
         @(negedge clk);
         got.push_back(out_event_msg);
         ack = 1'b1;
         @(negedge clk);
         ack = 1'b0;
         n++;
      end
      check_value(32'(ready), 32'd0, "ready right after the final ack");
      wait_level(1'b0, "ready after the final ack");
   endtask

   task automatic finish_test(input string name, input logic [NB_LPID-1:0] lp);
      check_value(32'(got.size()), 32'(exp_msgs.size()), "output message count");
      foreach (exp_msgs[i])
         if (i < got.size())
            check_value(got[i], exp_msgs[i], $sformatf("output message %0d", i));
      check_value(32'(wr_datas.size()), 32'(exp_wr.size()), "history write count");
      foreach (exp_wr[i])
         if (i < wr_datas.size()) begin
            check_value(32'(wr_addrs[i]), 32'(lp) * 16 + i, $sformatf("write address %0d", i));
            check_value(wr_datas[i], exp_wr[i], $sformatf("written entry %0d", i));
         end
      n_tests++;
      n_errors += test_errors;
      $display("test %s: %0d errors", name, test_errors);
   endtask

   initial begin
      rst_n = 1'b0;
      event_valid = 1'b0;
      cur_event_msg = '0;
      global_time = '0;
      random_in = '0;
      lp_mask = 3'b111;
      stall = 1'b0;
      ack = 1'b0;
      hist_size = '0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      start_test();
      run_event(3'd2, 1'b0, 16'd100, 16'd50, 0, 0);
      new_t = 16'd100 + 16'd10 + TIME_WID'(rnd[5:0]);
      new_tgt = rnd[10:8] & lp_mask;
      exp_msgs.push_back(make_msg(1'b0, new_tgt, new_t));
      exp_wr.push_back(make_entry(new_tgt, 8'(new_t - 16'd100), 1'b0, 16'd100));
      finish_test("fresh event", 3'd2);

      // two expired entries among four
      start_test();
      lp_mask = 3'b011;
      mem[80] = make_entry(3'd2, 8'd5, 1'b0, 16'd150);
      mem[81] = make_entry(3'd3, 8'd7, 1'b0, 16'd250);
      mem[82] = make_entry(3'd1, 8'd3, 1'b1, 16'd180);
      mem[83] = make_entry(3'd4, 8'd9, 1'b0, 16'd220);
      run_event(3'd5, 1'b0, 16'd300, 16'd200, 4, 0);
      new_t = 16'd300 + 16'd10 + TIME_WID'(rnd[5:0]);
      new_tgt = rnd[10:8] & lp_mask;
      exp_msgs.push_back(make_msg(1'b0, new_tgt, new_t));
      exp_wr.push_back(make_entry(3'd3, 8'd7, 1'b0, 16'd250));
      exp_wr.push_back(make_entry(3'd4, 8'd9, 1'b0, 16'd220));
      exp_wr.push_back(make_entry(new_tgt, 8'(new_t - 16'd300), 1'b0, 16'd300));
      finish_test("expired history", 3'd5);

      // straggler behind two later entries, held in stall-wait first
      start_test();
      lp_mask = 3'b111;
      mem[16] = make_entry(3'd2, 8'd11, 1'b0, 16'd350);
      mem[17] = make_entry(3'd4, 8'd12, 1'b0, 16'd450);
      mem[18] = make_entry(3'd6, 8'd20, 1'b0, 16'd500);
      run_event(3'd1, 1'b0, 16'd400, 16'd100, 3, 3);
      new_t = 16'd400 + 16'd10 + TIME_WID'(rnd[5:0]);
      new_tgt = rnd[10:8] & lp_mask;
      exp_msgs.push_back(make_msg(1'b0, new_tgt, new_t));
      exp_msgs.push_back(make_msg(1'b1, 3'd4, 16'd462));
      exp_msgs.push_back(make_msg(1'b0, 3'd1, 16'd450));
      exp_msgs.push_back(make_msg(1'b1, 3'd6, 16'd520));
      exp_msgs.push_back(make_msg(1'b0, 3'd1, 16'd500));
      exp_wr.push_back(make_entry(3'd2, 8'd11, 1'b0, 16'd350));
      exp_wr.push_back(make_entry(new_tgt, 8'(new_t - 16'd400), 1'b0, 16'd400));
      finish_test("straggler", 3'd1);

      start_test();
      mem[48] = make_entry(3'd2, 8'd15, 1'b0, 16'd600);
      mem[49] = make_entry(3'd5, 8'd30, 1'b0, 16'd550);
      run_event(3'd3, 1'b1, 16'd600, 16'd100, 2, 0);
      exp_msgs.push_back(make_msg(1'b1, 3'd2, 16'd615));
      exp_wr.push_back(make_entry(3'd5, 8'd30, 1'b0, 16'd550));
      finish_test("anti-message annihilation", 3'd3);

      // stored anti-message meets its regular event
      start_test();
      mem[96] = make_entry(3'd1, 8'd9, 1'b1, 16'd700);
      mem[97] = make_entry(3'd0, 8'd4, 1'b0, 16'd650);
      run_event(3'd6, 1'b0, 16'd700, 16'd100, 2, 0);
      exp_msgs.push_back(make_msg(1'b1, 3'd0, 16'd0));
      exp_wr.push_back(make_entry(3'd0, 8'd4, 1'b0, 16'd650));
      finish_test("regular annihilation", 3'd6);

      all_done = 1'b1;
   end

   initial begin
      wait (hung || all_done);
      $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               n_tests, n_checks, n_errors, DUT.u_asserts.fail_cnt);
      if (!hung && n_errors == 0 && DUT.u_asserts.fail_cnt == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* filelist.f */
hdl/phold_pkg.sv
hdl/phold_fifo.sv
hdl/core_sequencer.sv
hdl/event_generator.sv
hdl/history_filter.sv
hdl/event_sender.sv
hdl/phold_core.sv
verification/phold_core_asserts.sv
verification/phold_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the PHOLD core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module phold_core_tb -o phold_core_sim > build.log 2>&1 &&
   ./obj_dir/phold_core_sim +verilator+error+limit+100 > sim.log 2>&1 ||
   echo "build or simulation did not complete, see build.log and sim.log"
grep -q "^All checks passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
